// ==== stcMod_defs.svh ====
`ifndef STCMOD_DEFS_SVH
`define STCMOD_DEFS_SVH

//**************************************************************************
//                          Datapath widths
//**************************************************************************

// Samples and channel gains share one width
`define SAMPLE_WIDTH        18
`define DAC_WIDTH           14

//**************************************************************************
//                          Register bus
//**************************************************************************

`define DATA_WIDTH          32
// Word address of 16 slots with 8 mapped
`define ADDR_WIDTH          4

//**************************************************************************
//                          PN generator and symbols
//**************************************************************************

// Longest supported shift register
`define PN_MAX_LEN          24

// Full scale minus one LSB
`define SYMBOL_AMPLITUDE    131071

// LFSR state after reset and never the all-zero lockup
`define PN_SEED             24'hFF_FFFF

`endif

// ==== regMapPkg.sv ====
`include "stcMod_defs.svh"

package regMapPkg;

    // Word addresses of the control registers
    typedef enum logic [`ADDR_WIDTH-1:0] {
        REG_PN_TAPS    = 4'd0,
        REG_PN_LENGTH  = 4'd1,
        REG_H0_REAL    = 4'd2,
        REG_H0_IMAG    = 4'd3,
        REG_H1_REAL    = 4'd4,
        REG_H1_IMAG    = 4'd5,
        REG_DAC_SOURCE = 4'd6,      // DAC 0 in 3:0, DAC 1 in 7:4
        REG_TX_ENABLE  = 4'd7       // Bit 0 only
    } regAddr_t;

    // What each DAC shows
    typedef enum logic [3:0] {
        SRC_CH0_I = 4'd0,
        SRC_CH0_Q = 4'd1,
        SRC_CH1_I = 4'd2,
        SRC_CH1_Q = 4'd3,
        SRC_TX_I  = 4'd4,
        SRC_TX_Q  = 4'd5,
        SRC_POLY  = 4'd6            // Raw channel bit
    } dacSource_t;

endpackage

// ==== dspPkg.sv ====
`include "stcMod_defs.svh"

package dspPkg;

    //**********************************************************************
    //                     Sample and word types
    //**********************************************************************

    // Two's complement sample with full scale at +/- 2^17
    typedef logic signed [`SAMPLE_WIDTH-1:0] sample_t;

    // Complex channel gain component in sample format
    typedef logic signed [`SAMPLE_WIDTH-1:0] coef_t;

    // Offset binary DAC code with zero at mid-scale
    typedef logic [`DAC_WIDTH-1:0] dacWord_t;

endpackage

// ==== stcModRegs.sv ====
`timescale 1ns/1ps
`include "stcMod_defs.svh"

module stcModRegs (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    wr,
    input  regMapPkg::regAddr_t     addr,
    input  logic [`DATA_WIDTH-1:0]  writeData,
    output logic [`DATA_WIDTH-1:0]  readData,
    output logic [`PN_MAX_LEN-1:0]  pnPolyTaps,
    output logic [4:0]              pnPolyLength,
    output dspPkg::coef_t           h0Real,
    output dspPkg::coef_t           h0Imag,
    output dspPkg::coef_t           h1Real,
    output dspPkg::coef_t           h1Imag,
    output regMapPkg::dacSource_t   dac0Source,
    output regMapPkg::dacSource_t   dac1Source,
    output logic                    txEnable
);

    import regMapPkg::*;

    logic       txEnableReq;        // Requested level, as written
    logic [1:0] txEnableSR;

    //**********************************************************************
    //                          Register writes
    //**********************************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            pnPolyTaps   <= '0;
            pnPolyLength <= '0;
            h0Real       <= '0;
            h0Imag       <= '0;
            h1Real       <= '0;
            h1Imag       <= '0;
            dac0Source   <= SRC_CH0_I;
            dac1Source   <= SRC_CH0_I;
            txEnableReq  <= 1'b0;
        end
        else if (wr) begin
            case (addr)
                REG_PN_TAPS:    pnPolyTaps   <= writeData[`PN_MAX_LEN-1:0];
                REG_PN_LENGTH:  pnPolyLength <= writeData[4:0];
                REG_H0_REAL:    h0Real       <= writeData[`SAMPLE_WIDTH-1:0];
                REG_H0_IMAG:    h0Imag       <= writeData[`SAMPLE_WIDTH-1:0];
                REG_H1_REAL:    h1Real       <= writeData[`SAMPLE_WIDTH-1:0];
                REG_H1_IMAG:    h1Imag       <= writeData[`SAMPLE_WIDTH-1:0];
                REG_DAC_SOURCE: begin
                    dac0Source <= dacSource_t'(writeData[3:0]);
                    dac1Source <= dacSource_t'(writeData[7:4]);
                end
                REG_TX_ENABLE:  txEnableReq  <= writeData[0];
                default: ;                  // Write to unmapped address ignored
            endcase
        end
    end

    // Readback with upper bits zero
    always_comb begin
        readData = '0;
        case (addr)
            REG_PN_TAPS:    readData[`PN_MAX_LEN-1:0]   = pnPolyTaps;
            REG_PN_LENGTH:  readData[4:0]               = pnPolyLength;
            REG_H0_REAL:    readData[`SAMPLE_WIDTH-1:0] = h0Real;
            REG_H0_IMAG:    readData[`SAMPLE_WIDTH-1:0] = h0Imag;
            REG_H1_REAL:    readData[`SAMPLE_WIDTH-1:0] = h1Real;
            REG_H1_IMAG:    readData[`SAMPLE_WIDTH-1:0] = h1Imag;
            REG_DAC_SOURCE: readData[7:0]               = {dac1Source, dac0Source};
            REG_TX_ENABLE:  readData[0]                 = txEnableReq;
            default: ;
        endcase
    end

    //**********************************************************************
    //                     Transmit enable synchronizer
    //**********************************************************************
    // Both flops must agree before transmit starts
    always_ff @(posedge clk) begin
        if (reset) begin
            txEnableSR <= 2'b00;
            txEnable   <= 1'b0;
        end
        else begin
            txEnableSR <= {txEnableSR[0], txEnableReq};
            txEnable   <= txEnableSR[1] && txEnableSR[0];
        end
    end

endmodule

// ==== pnChannelSource.sv ====
`timescale 1ns/1ps
`include "stcMod_defs.svh"

module pnChannelSource (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    txEnable,
    input  logic [`PN_MAX_LEN-1:0]  pnPolyTaps,
    input  logic [4:0]              pnPolyLength,
    output logic                    stcBit0,
    output logic                    stcBit1
);

    logic [`PN_MAX_LEN-1:0] pnState;    // Bit 0 newest, bit lastIdx oldest
    logic [`PN_MAX_LEN-1:0] lenMask;
    logic [4:0]             lastIdx;
    logic                   feedback;
    logic                   pnBit;
    logic                   pairPhase;  // High once the channel 0 bit is held
    logic                   heldBit0;

    //**********************************************************************
    //                          PN generator
    //**********************************************************************

    // Clamp the programmed length to 1..PN_MAX_LEN
    always_comb begin
        if (pnPolyLength == 5'd0) begin
            lastIdx = 5'd0;
        end
        else if (pnPolyLength > `PN_MAX_LEN) begin
            lastIdx = 5'(`PN_MAX_LEN - 1);
        end
        else begin
            lastIdx = pnPolyLength - 5'd1;
        end
        for (int i = 0; i < `PN_MAX_LEN; i++) begin
            lenMask[i] = (i <= lastIdx);
        end
    end

    // Tap i picks the bit i+1 steps older than the one entering
    assign feedback = ^(pnPolyTaps & pnState & lenMask);
    assign pnBit    = pnState[lastIdx];

    always_ff @(posedge clk) begin
        if (reset) begin
            pnState <= `PN_SEED;
        end
        else if (txEnable) begin
            pnState <= {pnState[`PN_MAX_LEN-2:0], feedback};
        end
    end

    //**********************************************************************
    //                          Channel splitter
    //**********************************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            pairPhase <= 1'b0;
            stcBit0   <= 1'b0;
            stcBit1   <= 1'b0;
        end
        else if (txEnable) begin
            pairPhase <= ~pairPhase;
            if (pairPhase) begin            // Pair complete and presented together
                stcBit0 <= heldBit0;
                stcBit1 <= pnBit;
            end
        end
    end

    // Even bit waits here for its partner
    always_ff @(posedge clk) begin
        if (txEnable && !pairPhase) begin
            heldBit0 <= pnBit;
        end
    end

endmodule

// ==== channelModel.sv ====
`timescale 1ns/1ps
`include "stcMod_defs.svh"

module channelModel (
    input  logic            clk,
    input  logic            reset,
    input  logic            stcBit0,
    input  logic            stcBit1,
    input  dspPkg::coef_t   h0Real,
    input  dspPkg::coef_t   h0Imag,
    input  dspPkg::coef_t   h1Real,
    input  dspPkg::coef_t   h1Imag,
    output dspPkg::sample_t iCh0,
    output dspPkg::sample_t qCh0,
    output dspPkg::sample_t iCh1,
    output dspPkg::sample_t qCh1,
    output dspPkg::sample_t iTx,
    output dspPkg::sample_t qTx
);

    import dspPkg::*;

    localparam sample_t SYM_POS = sample_t'(`SYMBOL_AMPLITUDE);
    localparam sample_t SYM_NEG = sample_t'(-`SYMBOL_AMPLITUDE);

    sample_t sym0;
    sample_t sym1;
    logic    symValid;      // Pipeline filled since reset

    // Full product rescaled back to sample format
    function automatic sample_t scaleSym(sample_t sym, coef_t gain);
        logic signed [2*`SAMPLE_WIDTH-1:0] prod;
        prod = sym * gain;
        return prod[2*`SAMPLE_WIDTH-2 -: `SAMPLE_WIDTH];
    endfunction

    //**********************************************************************
    //                          Antipodal mapper
    //**********************************************************************
    always_ff @(posedge clk) begin
        sym0 <= stcBit0 ? SYM_POS : SYM_NEG;
        sym1 <= stcBit1 ? SYM_POS : SYM_NEG;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            symValid <= 1'b0;
        end
        else begin
            symValid <= 1'b1;
        end
    end

    //**********************************************************************
    //                     Channel gains and transmit sum
    //**********************************************************************
    // Real symbol, so each product is two real multiplies
    always_ff @(posedge clk) begin
        if (symValid) begin
            iCh0 <= scaleSym(sym0, h0Real);
            qCh0 <= scaleSym(sym0, h0Imag);
            iCh1 <= scaleSym(sym1, h1Real);
            qCh1 <= scaleSym(sym1, h1Imag);
        end
        else begin
            iCh0 <= '0;             // Symbols not yet mapped
            qCh0 <= '0;
            iCh1 <= '0;
            qCh1 <= '0;
        end
    end

    // Wraps on overflow
    always_ff @(posedge clk) begin
        iTx <= iCh0 + iCh1;
        qTx <= qCh0 + qCh1;
    end

endmodule

// ==== dacOutput.sv ====
`timescale 1ns/1ps
`include "stcMod_defs.svh"

module dacOutput (
    input  logic                    clk,
    input  logic                    reset,
    input  regMapPkg::dacSource_t   dac0Source,
    input  regMapPkg::dacSource_t   dac1Source,
    input  dspPkg::sample_t         iCh0,
    input  dspPkg::sample_t         qCh0,
    input  dspPkg::sample_t         iCh1,
    input  dspPkg::sample_t         qCh1,
    input  dspPkg::sample_t         iTx,
    input  dspPkg::sample_t         qTx,
    input  logic                    stcBit0,
    input  logic                    stcBit1,
    output dspPkg::dacWord_t        dac0Data,
    output dspPkg::dacWord_t        dac1Data
);

    import regMapPkg::*;
    import dspPkg::*;

    localparam dacWord_t MID_SCALE = dacWord_t'(1) << (`DAC_WIDTH - 1);

    sample_t sel0;
    sample_t sel1;

    function automatic sample_t pickSource(dacSource_t src, logic polyBit);
        sample_t pick;
        pick = '0;
        case (src)
            SRC_CH0_Q: pick = qCh0;
            SRC_CH1_I: pick = iCh1;
            SRC_CH1_Q: pick = qCh1;
            SRC_TX_I:  pick = iTx;
            SRC_TX_Q:  pick = qTx;
            SRC_POLY:  pick[`SAMPLE_WIDTH-2] = polyBit;   // Half scale or zero
            default:   pick = iCh0;                       // Also illegal codes
        endcase
        return pick;
    endfunction

    // Sign flipped and low bits dropped
    function automatic dacWord_t offsetBinary(sample_t s);
        return {~s[`SAMPLE_WIDTH-1], s[`SAMPLE_WIDTH-2 -: `DAC_WIDTH-1]};
    endfunction

    //**********************************************************************
    //                     Source select and formatting
    //**********************************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            sel0     <= '0;
            sel1     <= '0;
            dac0Data <= MID_SCALE;
            dac1Data <= MID_SCALE;
        end
        else begin
            sel0     <= pickSource(dac0Source, stcBit0);
            sel1     <= pickSource(dac1Source, stcBit1);
            dac0Data <= offsetBinary(sel0);
            dac1Data <= offsetBinary(sel1);
        end
    end

endmodule

// ==== stcModTop.sv ====
`timescale 1ns/1ps
`include "stcMod_defs.svh"

module stcModTop (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    wr,
    input  regMapPkg::regAddr_t     addr,
    input  logic [`DATA_WIDTH-1:0]  writeData,
    output logic [`DATA_WIDTH-1:0]  readData,
    output dspPkg::dacWord_t        dac0Data,
    output dspPkg::dacWord_t        dac1Data
);

    import regMapPkg::*;
    import dspPkg::*;

    logic [`PN_MAX_LEN-1:0] pnPolyTaps;
    logic [4:0]             pnPolyLength;
    coef_t                  h0Real, h0Imag;
    coef_t                  h1Real, h1Imag;
    dacSource_t             dac0Source, dac1Source;
    logic                   txEnable;
    logic                   stcBit0, stcBit1;
    sample_t                iCh0, qCh0;
    sample_t                iCh1, qCh1;
    sample_t                iTx, qTx;

    //**********************************************************************
    //                     Registers, PN source, channel, DACs
    //**********************************************************************
    stcModRegs i_regs (
        .clk(clk), .reset(reset),
        .wr(wr), .addr(addr), .writeData(writeData), .readData(readData),
        .pnPolyTaps(pnPolyTaps), .pnPolyLength(pnPolyLength),
        .h0Real(h0Real), .h0Imag(h0Imag), .h1Real(h1Real), .h1Imag(h1Imag),
        .dac0Source(dac0Source), .dac1Source(dac1Source),
        .txEnable(txEnable)
    );

    pnChannelSource i_pnSource (
        .clk(clk), .reset(reset), .txEnable(txEnable),
        .pnPolyTaps(pnPolyTaps), .pnPolyLength(pnPolyLength),
        .stcBit0(stcBit0), .stcBit1(stcBit1)
    );

    channelModel i_channel (
        .clk(clk), .reset(reset), .stcBit0(stcBit0), .stcBit1(stcBit1),
        .h0Real(h0Real), .h0Imag(h0Imag), .h1Real(h1Real), .h1Imag(h1Imag),
        .iCh0(iCh0), .qCh0(qCh0), .iCh1(iCh1), .qCh1(qCh1), .iTx(iTx), .qTx(qTx)
    );

    dacOutput i_dac (
        .clk(clk), .reset(reset), .dac0Source(dac0Source), .dac1Source(dac1Source),
        .iCh0(iCh0), .qCh0(qCh0), .iCh1(iCh1), .qCh1(qCh1), .iTx(iTx), .qTx(qTx),
        .stcBit0(stcBit0), .stcBit1(stcBit1),
        .dac0Data(dac0Data), .dac1Data(dac1Data)
    );

endmodule

// ==== stcModTop_props.sv ====
`timescale 1ns/1ps
`include "stcMod_defs.svh"

module stcModTopProps (
    input logic                    clk,
    input logic                    reset,
    input logic                    txEnableReq,
    input logic                    txEnable,
    input logic [`ADDR_WIDTH-1:0]  addr,
    input logic [`DATA_WIDTH-1:0]  readData,
    input logic [`DAC_WIDTH-1:0]   dac0Data,
    input logic [`DAC_WIDTH-1:0]   dac1Data
);

    localparam logic [`DAC_WIDTH-1:0] MID_SCALE = 1 << (`DAC_WIDTH - 1);

    logic midScale;
    int   failCount = 0;                    // Failed assertion count

    assign midScale = (dac0Data == MID_SCALE) && (dac1Data == MID_SCALE);

    // Request must pass both synchronizer flops
    assert property (@(posedge clk) disable iff (reset)
        $rose(txEnable) |-> $past(txEnableReq, 1) && $past(txEnableReq, 2))
    else begin
        $error("txEnable rose without a two-cycle enable request");
        failCount++;
    end

    assert property (@(posedge clk) $fell(reset) |-> midScale ##1 midScale ##1 midScale)
    else begin
        $error("DAC outputs left mid-scale right after reset");
        failCount++;
    end

    assert property (@(posedge clk) (addr > 4'd7) |-> (readData == '0))
    else begin
        $error("readData nonzero for an unmapped address");
        failCount++;
    end

endmodule

bind stcModTop stcModTopProps i_props (
    .clk(clk), .reset(reset), .txEnableReq(i_regs.txEnableReq), .txEnable(txEnable),
    .addr(addr), .readData(readData), .dac0Data(dac0Data), .dac1Data(dac1Data)
);

// ==== tb_stcModTop.sv ====
`timescale 1ns/1ps
`include "stcMod_defs.svh"

module tb_stcModTop;

    import regMapPkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_ROWS   = 8;
    localparam int ROW_CYCLES = 250;            // Longest row is a PN check plus hold
    localparam int NUM_BITS   = 96;
    localparam logic [1:0] MODE_CODES = 2'd0;
    localparam logic [1:0] MODE_PN    = 2'd1;
    localparam logic [1:0] MODE_HOLD  = 2'd2;

    typedef struct packed {
        logic [1:0]  mode;
        logic [23:0] taps;
        logic [4:0]  len;
        logic [71:0] gains;                     // h0 real, h0 imag, h1 real, h1 imag
        logic [7:0]  srcs;                      // DAC 1 source above DAC 0 source
        logic        en;
        logic [27:0] codes;                     // DAC 1 code above DAC 0 code
    } row_t;

    logic                   clk = 1'b0;
    logic                   reset = 1'b1;
    logic                   wr = 1'b0;
    regAddr_t               addr = REG_PN_TAPS;
    logic [`DATA_WIDTH-1:0] writeData = '0;
    logic [`DATA_WIDTH-1:0] readData;
    logic [`DAC_WIDTH-1:0]  dac0Data;
    logic [`DAC_WIDTH-1:0]  dac1Data;
    row_t                   testRows [NUM_ROWS];
    int                     rowCount = 0;
    logic [15:0]            lfsr = 16'd85;
    logic                   stream [NUM_BITS];  // Merged PN bits, oldest first
    int                     rowErrors = 0;
    int                     testNum = 0;
    int                     failedTests = 0;

    stcModTop i_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    //**********************************************************************
    //                          Reference model
    //**********************************************************************
    function automatic logic [17:0] randomGain();
        logic [17:0] g;
        g = '0;
        for (int i = 0; i < 18; i++) begin
            g    = {g[16:0], lfsr[0]};          // Galois step per bit
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 16'hB400 : 16'h0000);
        end
        return g;
    endfunction

    // Antipodal symbol times gain kept at bits 34:17
    function automatic logic [17:0] chanProduct(logic symBit, logic [17:0] gain);
        logic signed [35:0] amp;
        logic signed [35:0] prod;
        amp  = `SYMBOL_AMPLITUDE;
        prod = (symBit ? amp : -amp) * $signed({{18{gain[17]}}, gain});
        return prod[34:17];
    endfunction

    function automatic logic [13:0] dacCode(logic [17:0] s);
        return {~s[17], s[16:4]};               // Offset binary
    endfunction

    // Both channel bits low in the code rows
    function automatic logic [13:0] expectedCode(logic [3:0] src, logic [71:0] g);
        logic [17:0] c0i;
        logic [17:0] c0q;
        logic [17:0] c1i;
        logic [17:0] c1q;
        c0i = chanProduct(1'b0, g[71:54]);
        c0q = chanProduct(1'b0, g[53:36]);
        c1i = chanProduct(1'b0, g[35:18]);
        c1q = chanProduct(1'b0, g[17:0]);
        case (src)
            SRC_CH0_Q: return dacCode(c0q);
            SRC_CH1_I: return dacCode(c1i);
            SRC_CH1_Q: return dacCode(c1q);
            SRC_TX_I:  return dacCode(c0i + c1i);
            SRC_TX_Q:  return dacCode(c0q + c1q);
            SRC_POLY:  return dacCode(18'd0);
            default:   return dacCode(c0i);
        endcase
    endfunction

    function automatic logic [31:0] regMask(logic [3:0] a);
        case (a)
            REG_PN_TAPS:    return 32'({`PN_MAX_LEN{1'b1}});
            REG_PN_LENGTH:  return 32'h1F;
            REG_H0_REAL, REG_H0_IMAG, REG_H1_REAL, REG_H1_IMAG:
                            return 32'({`SAMPLE_WIDTH{1'b1}});
            REG_DAC_SOURCE: return 32'hFF;
            REG_TX_ENABLE:  return 32'h1;
            default:        return 32'h0;       // Unmapped
        endcase
    endfunction

    //**********************************************************************
    //                          Bus and check tasks
    //**********************************************************************
    task automatic checkValue(string name, logic [31:0] got, logic [31:0] want);
        assert (got === want) else begin
            $display("** Error @ %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, want);
            rowErrors++;
        end
    endtask

    // Called on a falling edge and returns on the next one
    task automatic writeReg(logic [3:0] a, logic [31:0] d);
        addr      = regAddr_t'(a);
        writeData = d;
        wr        = 1'b1;
        @(negedge clk);
        wr        = 1'b0;
    endtask

    task automatic pulseReset();
        reset = 1'b1;
        repeat (5) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic addRow(logic [1:0] mode, logic [23:0] taps, logic [4:0] len,
                          logic [7:0] srcs);
        row_t r;
        r.mode  = mode;
        r.taps  = taps;
        r.len   = len;
        r.srcs  = srcs;
        r.en    = (mode != MODE_CODES);
        r.gains = '0;
        if (mode == MODE_CODES) begin
            r.gains = {randomGain(), randomGain(), randomGain(), randomGain()};
        end
        r.codes = {expectedCode(srcs[7:4], r.gains), expectedCode(srcs[3:0], r.gains)};
        testRows[rowCount] = r;
        rowCount++;
    endtask

    task automatic configure(row_t r);
        writeReg(REG_PN_TAPS, r.taps);
        writeReg(REG_PN_LENGTH, r.len);
        writeReg(REG_H0_REAL, r.gains[71:54]);
        writeReg(REG_H0_IMAG, r.gains[53:36]);
        writeReg(REG_H1_REAL, r.gains[35:18]);
        writeReg(REG_H1_IMAG, r.gains[17:0]);
        writeReg(REG_DAC_SOURCE, r.srcs);
        writeReg(REG_TX_ENABLE, r.en);          // Enable last
    endtask

    task automatic checkRecurrence(row_t r);
        logic want;
        int   k;
        pulseReset();
        configure(r);
        k = 0;
        while (dac0Data == dacCode(18'd0) && dac1Data == dacCode(18'd0) && k < 40) begin
            @(negedge clk);
            k++;
        end
        if (k == 40) begin
            $display("PN bits never reached the DACs after transmit was enabled");
            rowErrors++;
            return;
        end
        // Pairs arrive every second cycle from the first change on
        for (int n = 0; n < NUM_BITS; n += 2) begin
            stream[n]     = (dac0Data == dacCode(18'h10000));
            stream[n + 1] = (dac1Data == dacCode(18'h10000));
            repeat (2) @(negedge clk);
        end
        for (int n = r.len; n < NUM_BITS; n++) begin
            want = 1'b0;
            for (int i = 0; i < r.len; i++) begin
                want ^= r.taps[i] & stream[n - 1 - i];
            end
            checkValue($sformatf("pnBit[%0d]", n), stream[n], want);
        end
    endtask

    task automatic holdAndResume();
        logic [27:0] held;
        int          k;
        writeReg(REG_TX_ENABLE, 0);
        repeat (6) @(negedge clk);              // Synchronizer plus DAC pipeline
        held = {dac1Data, dac0Data};
        repeat (40) begin
            @(negedge clk);
            checkValue("{dac1Data, dac0Data}", {dac1Data, dac0Data}, held);
        end
        writeReg(REG_TX_ENABLE, 1);
        k = 0;
        while ({dac1Data, dac0Data} == held && k < 60) begin
            @(negedge clk);
            k++;
        end
        if (k == 60) begin
            $display("DAC codes did not resume changing after transmit was enabled again");
            rowErrors++;
        end
    endtask

    task automatic endTest(string name);
        testNum++;
        if (rowErrors != 0) begin
            failedTests++;
        end
        $display("Test %0d, %s: %s", testNum, name, (rowErrors == 0) ? "ok" : "FAILED");
        rowErrors = 0;
    endtask

    //**********************************************************************
    //                          Test sequence
    //**********************************************************************
    initial begin
        addRow(MODE_CODES, 24'h0, 5'd0, {SRC_CH0_Q, SRC_CH0_I});
        addRow(MODE_CODES, 24'h0, 5'd0, {SRC_CH1_Q, SRC_CH1_I});
        addRow(MODE_CODES, 24'h0, 5'd0, {SRC_TX_Q, SRC_TX_I});
        addRow(MODE_CODES, 24'h0, 5'd0, {SRC_POLY, SRC_TX_I});
        addRow(MODE_PN, 24'h000014, 5'd5, {SRC_POLY, SRC_POLY});
        addRow(MODE_PN, 24'h000060, 5'd7, {SRC_POLY, SRC_POLY});
        addRow(MODE_PN, 24'hE10000, 5'd24, {SRC_POLY, SRC_POLY});
        addRow(MODE_HOLD, 24'h000110, 5'd9, {SRC_POLY, SRC_POLY});
        pulseReset();

        checkValue("dac0Data", dac0Data, dacCode(18'd0));
        checkValue("dac1Data", dac1Data, dacCode(18'd0));
        for (int a = 0; a < 16; a++) begin
            addr = regAddr_t'(a);
            @(negedge clk);
            checkValue($sformatf("readData[%0d]", a), readData, 32'h0);
        end
        endTest("reset values");

        for (int a = 0; a < 16; a++) begin
            writeReg(a, '1);
            checkValue($sformatf("readData[%0d]", a), readData, regMask(a));
            if (a == REG_TX_ENABLE) begin
                writeReg(a, 0);                 // One-cycle request that never passes the synchronizer
            end
        end
        endTest("register readback");

        for (int r = 0; r < NUM_ROWS; r++) begin
            case (testRows[r].mode)
                MODE_CODES: begin
                    configure(testRows[r]);
                    repeat (6) @(negedge clk);
                    checkValue("dac0Data", dac0Data, testRows[r].codes[13:0]);
                    checkValue("dac1Data", dac1Data, testRows[r].codes[27:14]);
                end
                MODE_PN: checkRecurrence(testRows[r]);
                default: begin
                    checkRecurrence(testRows[r]);
                    holdAndResume();
                end
            endcase
            endTest($sformatf("table row %0d", r));
        end

        checkValue("bound property failures", i_dut.i_props.failCount, 0);
        endTest("bound properties");

        $display("%0d tests, %0d passed, %0d failed", testNum, testNum - failedTests,
                 failedTests);
        if (failedTests == 0) begin
            $display("Simulation passed");
        end
        else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #((NUM_ROWS * ROW_CYCLES + 200) * CLK_PERIOD);
        $display("Watchdog expired before the test sequence finished");
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+.
regMapPkg.sv
dspPkg.sv
stcModRegs.sv
pnChannelSource.sv
channelModel.sv
dacOutput.sv
stcModTop.sv
stcModTop_props.sv
tb_stcModTop.sv

// ==== Bender.yml ====
package:
  name: stc_mod

sources:
  - include_dirs:
      - .
    files:
      - regMapPkg.sv
      - dspPkg.sv
      - stcModRegs.sv
      - pnChannelSource.sv
      - channelModel.sv
      - dacOutput.sv
      - stcModTop.sv
      - target: simulation
        files:
          - stcModTop_props.sv
          - tb_stcModTop.sv
